// ==== Makefile ====
# Verilator build and run for the work-ram subsystem

VERILATOR ?= verilator
TOP       ?= tb_gba_mem
FILELIST  ?= gba_mem.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_TEXT ?= No errors

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// ==== gba_mem.f ====
rtl/gba_bus_pkg.sv
rtl/work_ram.sv
rtl/mem_arbiter.sv
rtl/cart_loader.sv
rtl/dma_channel.sv
rtl/cpu_port.sv
rtl/gba_mem_top.sv
testbench/gba_mem_asserts.sv
testbench/tb_gba_mem.sv

// ==== rtl/cart_loader.sv ====
// cartridge loader
// packs the byte stream little-endian into words, writes them from address 0
// and raises gba_on once the last word is in ram

`timescale 1ns/100ps

module cart_loader (
    input  logic                  clk16,
    input  logic                  resetn,
    input  logic                  loading,
    input  logic [7:0]            loader_data,
    input  logic                  loader_valid,
    output logic                  gba_on,
    output gba_bus_pkg::bus_req_t bus_req,
    input  gba_bus_pkg::bus_rsp_t bus_rsp
);

    logic [31:0]             word_buf;
    logic [1:0]              fill;       // bytes already in word_buf
    gba_bus_pkg::word_addr_t waddr;
    logic                    loading_q;
    logic                    closing;    // loading ended, last write still out
    logic                    on_r;

    logic       first;      // loading just rose
    logic       ending;     // loading just fell
    logic       take;
    logic [1:0] lane;
    logic       full_word;
    logic       last_part;

    assign first     = loading & ~loading_q;
    assign ending    = ~loading & loading_q;
    assign take      = loading & loader_valid;
    assign lane      = first ? 2'd0 : fill;
    assign full_word = take & (lane == 2'd3);
    assign last_part = ending & (fill != 2'd0);

    assign gba_on = on_r & ~loading;   // off as soon as a new load starts

    always_ff @(posedge clk16) begin
        // data path
        if (take)
            word_buf[{lane, 3'b000} +: 8] <= loader_data;
        if (full_word) begin
            bus_req.write <= 1'b1;
            bus_req.addr  <= waddr;
            bus_req.wdata <= {loader_data, word_buf[23:0]};
            bus_req.be    <= 4'b1111;
        end else if (last_part) begin
            bus_req.write <= 1'b1;
            bus_req.addr  <= waddr;
            bus_req.wdata <= word_buf;
            bus_req.be    <= ~(4'b1111 << fill);  // filled lanes only
        end

        // control
        if (!resetn) begin
            bus_req.valid <= 1'b0;
            fill          <= 2'd0;
            waddr         <= '0;
            loading_q     <= 1'b0;
            closing       <= 1'b0;
            on_r          <= 1'b0;
        end else begin
            loading_q <= loading;
            if (bus_rsp.done)
                bus_req.valid <= 1'b0;
            if (full_word || last_part)
                bus_req.valid <= 1'b1;

            if (first) begin
                waddr   <= '0;
                fill    <= 2'd0;
                closing <= 1'b0;
                on_r    <= 1'b0;
            end
            if (take)
                fill <= lane + 2'd1;          // wraps to 0 on a full word
            if (full_word)
                waddr <= waddr + 1'b1;

            if (last_part) begin
                fill    <= 2'd0;
                closing <= 1'b1;
            end else if (ending) begin
                if (bus_req.valid && !bus_rsp.done)
                    closing <= 1'b1;          // wait for the last full word
                else
                    on_r <= 1'b1;
            end

            if (closing && bus_rsp.done) begin
                closing <= 1'b0;
                on_r    <= 1'b1;
            end
        end
    end

endmodule

// ==== rtl/cpu_port.sv ====
// cpu data port
// turns one four-phase request from outside into one bus transaction

`timescale 1ns/100ps

module cpu_port (
    input  logic                  clk16,
    input  logic                  resetn,
    input  logic                  gba_on,
    input  logic                  cpu_req,
    input  gba_bus_pkg::cpu_cmd_t cpu_cmd,
    output logic                  cpu_ack,
    output logic [31:0]           cpu_rdata,
    output gba_bus_pkg::bus_req_t bus_req,
    input  gba_bus_pkg::bus_rsp_t bus_rsp
);

    typedef enum logic [1:0] {S_IDLE, S_BUS, S_ACK} state_t;

    state_t                state;
    gba_bus_pkg::cpu_cmd_t cmd_r;
    logic                  start;

    assign start   = (state == S_IDLE) && cpu_req && gba_on;  // held off until loaded
    assign cpu_ack = (state == S_ACK);

    always_comb begin
        bus_req.valid = (state == S_BUS);
        bus_req.write = cmd_r.write;
        bus_req.addr  = cmd_r.addr[gba_bus_pkg::ADDR_BITS-1:2];
        bus_req.wdata = cmd_r.wdata;
        bus_req.be    = gba_bus_pkg::byte_lanes(cmd_r.size, cmd_r.addr[1:0]);
    end

    always_ff @(posedge clk16) begin
        if (start)
            cmd_r <= cpu_cmd;
        if (state == S_BUS && bus_rsp.done)
            cpu_rdata <= bus_rsp.rdata;   // whole word, held through ack

        if (!resetn) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE:  if (start) state <= S_BUS;
                S_BUS:   if (bus_rsp.done) state <= S_ACK;
                S_ACK:   if (!cpu_req) state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

// ==== rtl/dma_channel.sv ====
// single dma channel
// copies count units of byte, halfword or word size from src to dst,
// one read then one write per unit, started by a four-phase req/ack

`timescale 1ns/100ps

module dma_channel (
    input  logic                  clk16,
    input  logic                  resetn,
    input  logic                  gba_on,
    input  logic                  dma_req,
    input  gba_bus_pkg::dma_cmd_t dma_cmd,
    output logic                  dma_ack,
    output gba_bus_pkg::bus_req_t bus_req,
    input  gba_bus_pkg::bus_rsp_t bus_rsp
);

    typedef enum logic [1:0] {S_IDLE, S_READ, S_WRITE, S_ACK} state_t;

    state_t                               state;
    gba_bus_pkg::byte_addr_t              src, dst;
    gba_bus_pkg::byte_addr_t              step, cmd_step;
    logic [gba_bus_pkg::COUNT_BITS-1:0]   count;
    gba_bus_pkg::acc_size_t               size;
    logic [31:0]                          data_r;
    logic [1:0]                           shift;    // lane offset dst - src
    logic [63:0]                          spread;
    logic                                 start;
    logic                                 wr_done;

    assign start    = (state == S_IDLE) && dma_req && gba_on;
    assign wr_done  = (state == S_WRITE) && bus_rsp.done;
    assign step     = gba_bus_pkg::byte_addr_t'(1) << size;
    assign cmd_step = gba_bus_pkg::byte_addr_t'(1) << dma_cmd.size;

    // move source lanes onto destination lanes
    assign shift  = dst[1:0] - src[1:0];
    assign spread = {bus_rsp.rdata, bus_rsp.rdata} << {shift, 3'b000};

    assign dma_ack = (state == S_ACK);

    always_comb begin
        bus_req.valid = (state == S_READ) || (state == S_WRITE);
        bus_req.write = (state == S_WRITE);
        bus_req.wdata = data_r;
        if (state == S_WRITE) begin
            bus_req.addr = dst[gba_bus_pkg::ADDR_BITS-1:2];
            bus_req.be   = gba_bus_pkg::byte_lanes(size, dst[1:0]);
        end else begin
            bus_req.addr = src[gba_bus_pkg::ADDR_BITS-1:2];
            bus_req.be   = gba_bus_pkg::byte_lanes(size, src[1:0]);
        end
    end

    always_ff @(posedge clk16) begin
        // addresses and data
        if (start) begin
            src  <= dma_cmd.src & ~(cmd_step - 1'b1);  // units are size aligned
            dst  <= dma_cmd.dst & ~(cmd_step - 1'b1);
            size <= dma_cmd.size;
        end else if (wr_done) begin
            src <= src + step;
            dst <= dst + step;
        end
        if (state == S_READ && bus_rsp.done)
            data_r <= spread[63:32];

        // sequencing
        if (!resetn) begin
            state <= S_IDLE;
            count <= '0;
        end else begin
            case (state)
                S_IDLE: if (start) begin
                    count <= dma_cmd.count;
                    state <= (dma_cmd.count == '0) ? S_ACK : S_READ;  // empty copy acks at once
                end
                S_READ: if (bus_rsp.done)
                    state <= S_WRITE;
                S_WRITE: if (bus_rsp.done) begin
                    count <= count - 1'b1;
                    state <= (count == 1) ? S_ACK : S_READ;
                end
                S_ACK: if (!dma_req)
                    state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

// ==== rtl/gba_bus_pkg.sv ====
// work-ram bus definitions
// sizes, access widths, request/response structs and the byte-lane rule

package gba_bus_pkg;

    //////////////////////////////////////////////////
    // sizes
    //////////////////////////////////////////////////
    localparam int RAM_WORD_BITS = 12;                // 4k words, 16 KiB
    localparam int ADDR_BITS     = RAM_WORD_BITS + 2; // byte address
    localparam int COUNT_BITS    = 16;                // dma unit count

    typedef logic [ADDR_BITS-1:0]     byte_addr_t;
    typedef logic [RAM_WORD_BITS-1:0] word_addr_t;

    typedef enum logic [1:0] {
        ACC_BYTE = 2'b00,
        ACC_HALF = 2'b01,
        ACC_WORD = 2'b10
    } acc_size_t;

    //////////////////////////////////////////////////
    // bus and command records
    //////////////////////////////////////////////////
    typedef struct packed {
        logic        valid;
        logic        write;
        word_addr_t  addr;
        logic [31:0] wdata;
        logic [3:0]  be;     // one bit per byte lane
    } bus_req_t;

    typedef struct packed {
        logic        done;   // one cycle, rdata valid with it
        logic [31:0] rdata;
    } bus_rsp_t;

    typedef struct packed {
        byte_addr_t            src;
        byte_addr_t            dst;
        logic [COUNT_BITS-1:0] count;  // units, not bytes
        acc_size_t             size;
    } dma_cmd_t;

    typedef struct packed {
        byte_addr_t  addr;
        logic        write;
        acc_size_t   size;
        logic [31:0] wdata;  // already sitting in its lanes
    } cpu_cmd_t;

    // lanes touched by an access of this size at this byte offset
    function automatic logic [3:0] byte_lanes(acc_size_t size, logic [1:0] lo);
        case (size)
            ACC_BYTE: return 4'b0001 << lo;
            ACC_HALF: return lo[1] ? 4'b1100 : 4'b0011;
            ACC_WORD: return 4'b1111;
            default:  return 4'b0000;
        endcase
    endfunction

endpackage

// ==== rtl/gba_mem_top.sv ====
// memory side of the console
// cartridge loader, dma channel and cpu port sharing one work ram

`timescale 1ns/100ps

module gba_mem_top (
    input  logic                  clk16,
    input  logic                  resetn,
    input  logic                  loading,
    input  logic [7:0]            loader_data,
    input  logic                  loader_valid,
    output logic                  gba_on,
    input  logic                  dma_req,
    input  gba_bus_pkg::dma_cmd_t dma_cmd,
    output logic                  dma_ack,
    input  logic                  cpu_req,
    input  gba_bus_pkg::cpu_cmd_t cpu_cmd,
    output logic                  cpu_ack,
    output logic [31:0]           cpu_rdata
);

    gba_bus_pkg::bus_req_t ld_bus_req, dma_bus_req, cpu_bus_req, ram_req;
    gba_bus_pkg::bus_rsp_t ld_bus_rsp, dma_bus_rsp, cpu_bus_rsp, ram_rsp;

    cart_loader loader (
        .clk16(clk16), .resetn(resetn),
        .loading(loading), .loader_data(loader_data), .loader_valid(loader_valid),
        .gba_on(gba_on),
        .bus_req(ld_bus_req), .bus_rsp(ld_bus_rsp)
    );

    dma_channel dma (
        .clk16(clk16), .resetn(resetn), .gba_on(gba_on),
        .dma_req(dma_req), .dma_cmd(dma_cmd), .dma_ack(dma_ack),
        .bus_req(dma_bus_req), .bus_rsp(dma_bus_rsp)
    );

    cpu_port cpu (
        .clk16(clk16), .resetn(resetn), .gba_on(gba_on),
        .cpu_req(cpu_req), .cpu_cmd(cpu_cmd), .cpu_ack(cpu_ack), .cpu_rdata(cpu_rdata),
        .bus_req(cpu_bus_req), .bus_rsp(cpu_bus_rsp)
    );

    mem_arbiter arb (
        .clk16(clk16), .resetn(resetn),
        .ld_req(ld_bus_req), .dma_req(dma_bus_req), .cpu_req(cpu_bus_req),
        .ld_rsp(ld_bus_rsp), .dma_rsp(dma_bus_rsp), .cpu_rsp(cpu_bus_rsp),
        .ram_req(ram_req), .ram_rsp(ram_rsp)
    );

    work_ram wram (
        .clk16(clk16),
        .req(ram_req), .rsp(ram_rsp)
    );

endmodule

// ==== rtl/mem_arbiter.sv ====
// work ram arbiter
// fixed priority loader > dma > cpu, one transaction in flight at a time

`timescale 1ns/100ps

module mem_arbiter (
    input  logic                  clk16,
    input  logic                  resetn,
    input  gba_bus_pkg::bus_req_t ld_req,
    input  gba_bus_pkg::bus_req_t dma_req,
    input  gba_bus_pkg::bus_req_t cpu_req,
    output gba_bus_pkg::bus_rsp_t ld_rsp,
    output gba_bus_pkg::bus_rsp_t dma_rsp,
    output gba_bus_pkg::bus_rsp_t cpu_rsp,
    output gba_bus_pkg::bus_req_t ram_req,
    input  gba_bus_pkg::bus_rsp_t ram_rsp
);

    logic [2:0] pick;    // one-hot {cpu, dma, ld}, only while idle
    logic [2:0] owner;   // who gets the next done
    logic       busy;    // forwarded, done not yet back

    // response copy for one requester
    function automatic gba_bus_pkg::bus_rsp_t route(logic sel, gba_bus_pkg::bus_rsp_t rsp);
        gba_bus_pkg::bus_rsp_t r;
        r.done  = sel & rsp.done;
        r.rdata = sel ? rsp.rdata : 32'h0;
        return r;
    endfunction

    //////////////////////////////////////////////////
    // grant
    //////////////////////////////////////////////////
    always_comb begin
        pick = 3'b000;
        if (!busy) begin
            if (ld_req.valid)
                pick = 3'b001;
            else if (dma_req.valid)
                pick = 3'b010;
            else if (cpu_req.valid)
                pick = 3'b100;
        end
    end

    always_comb begin
        case (pick)
            3'b001:  ram_req = ld_req;
            3'b010:  ram_req = dma_req;
            3'b100:  ram_req = cpu_req;
            default: ram_req = '0;      // nothing forwarded this cycle
        endcase
    end

    always_ff @(posedge clk16) begin
        if (!resetn) begin
            busy  <= 1'b0;
            owner <= 3'b000;
        end else if (busy) begin
            if (ram_rsp.done)
                busy <= 1'b0;
        end else if (pick != 3'b000) begin
            busy  <= 1'b1;
            owner <= pick;
        end
    end

    //////////////////////////////////////////////////
    // responses
    //////////////////////////////////////////////////
    assign ld_rsp  = route(owner[0], ram_rsp);
    assign dma_rsp = route(owner[1], ram_rsp);
    assign cpu_rsp = route(owner[2], ram_rsp);

endmodule

// ==== rtl/work_ram.sv ====
// work ram
// word-wide synchronous memory with byte lanes, registered read data
// and a done one cycle after every valid request

`timescale 1ns/100ps

module work_ram (
    input  logic                  clk16,
    input  gba_bus_pkg::bus_req_t req,
    output gba_bus_pkg::bus_rsp_t rsp
);

    localparam int WORDS = 1 << gba_bus_pkg::RAM_WORD_BITS;

    logic [31:0] mem [0:WORDS-1];

    always_ff @(posedge clk16) begin
        if (req.valid && req.write) begin
            for (int i = 0; i < 4; i++) begin
                if (req.be[i])
                    mem[req.addr][8*i +: 8] <= req.wdata[8*i +: 8];
            end
        end
        if (req.valid)
            rsp.rdata <= mem[req.addr];   // old word on a write
        rsp.done <= req.valid;
    end

endmodule

// ==== testbench/gba_mem_asserts.sv ====
// bus and handshake checks for the work-ram subsystem
// bound into gba_mem_top

`timescale 1ns/100ps

module gba_mem_asserts (
    input logic                  clk16,
    input logic                  resetn,
    input logic                  loading,
    input logic                  gba_on,
    input logic                  dma_req,
    input logic                  dma_ack,
    input logic                  cpu_req,
    input logic                  cpu_ack,
    input gba_bus_pkg::bus_req_t ld_bus_req,
    input gba_bus_pkg::bus_req_t dma_bus_req,
    input gba_bus_pkg::bus_req_t cpu_bus_req,
    input gba_bus_pkg::bus_rsp_t ld_rsp,
    input gba_bus_pkg::bus_rsp_t dma_rsp,
    input gba_bus_pkg::bus_rsp_t cpu_rsp,
    input gba_bus_pkg::bus_req_t ram_req
);

    int fail_count = 0;  // failed assertions so far

    //////////////////////////////////////////////////
    // four-phase handshakes
    //////////////////////////////////////////////////
    dma_ack_needs_req: assert property (@(posedge clk16) disable iff (!resetn)
        $rose(dma_ack) |-> $past(dma_req))
        else begin
            fail_count++;
            $error("dma_ack rose without dma_req");
        end

    cpu_ack_needs_req: assert property (@(posedge clk16) disable iff (!resetn)
        $rose(cpu_ack) |-> $past(cpu_req))
        else begin
            fail_count++;
            $error("cpu_ack rose without cpu_req");
        end

    //////////////////////////////////////////////////
    // arbiter and ram
    //////////////////////////////////////////////////
    // done to one requester at most, and only to one still waiting
    one_done: assert property (@(posedge clk16) disable iff (!resetn)
        $onehot0({ld_rsp.done, dma_rsp.done, cpu_rsp.done})
        && (!ld_rsp.done || ld_bus_req.valid)
        && (!dma_rsp.done || dma_bus_req.valid)
        && (!cpu_rsp.done || cpu_bus_req.valid))
        else begin
            fail_count++;
            $error("done routed to more than one or an idle requester");
        end

    // a forwarded request comes from the highest valid requester
    ld_done_after_fwd: assert property (@(posedge clk16) disable iff (!resetn)
        ram_req.valid && ld_bus_req.valid |=> ld_rsp.done)
        else begin
            fail_count++;
            $error("forwarded loader request got no done");
        end

    dma_done_after_fwd: assert property (@(posedge clk16) disable iff (!resetn)
        ram_req.valid && !ld_bus_req.valid && dma_bus_req.valid |=> dma_rsp.done)
        else begin
            fail_count++;
            $error("forwarded dma request got no done");
        end

    cpu_done_after_fwd: assert property (@(posedge clk16) disable iff (!resetn)
        ram_req.valid && !ld_bus_req.valid && !dma_bus_req.valid |=> cpu_rsp.done)
        else begin
            fail_count++;
            $error("forwarded cpu request got no done");
        end

    // also low in the cycle after loading falls, so the old gba_on was cleared
    off_while_loading: assert property (@(posedge clk16) disable iff (!resetn)
        loading |-> !gba_on ##1 !gba_on)
        else begin
            fail_count++;
            $error("gba_on high during loading");
        end

endmodule

bind gba_mem_top gba_mem_asserts chk0 (
    .clk16(clk16), .resetn(resetn), .loading(loading), .gba_on(gba_on),
    .dma_req(dma_req), .dma_ack(dma_ack), .cpu_req(cpu_req), .cpu_ack(cpu_ack),
    .ld_bus_req(ld_bus_req), .dma_bus_req(dma_bus_req), .cpu_bus_req(cpu_bus_req),
    .ld_rsp(ld_bus_rsp), .dma_rsp(dma_bus_rsp), .cpu_rsp(cpu_bus_rsp),
    .ram_req(ram_req)
);

// ==== testbench/tb_gba_mem.sv ====
// testbench for the work-ram subsystem
// random loads, cpu accesses and dma copies checked against a byte model

`timescale 1ns/100ps

module tb_gba_mem;

    localparam int CLK_PERIOD = 100;
    localparam int DRIVE_DLY  = 10;
    localparam int REGION     = 256;        // bytes under test, all filled by test 1
    localparam int WORDS      = REGION / 4;
    localparam int N_LOADS    = 3;
    localparam int N_WRITES   = 48;
    localparam int N_COPIES   = 6;
    localparam int N_CONC     = 12;
    localparam int ACK_LIMIT  = 200;        // cycles per handshake phase
    localparam int TEST_CYCLES = (REGION * 3 + 100) + N_LOADS * (64 * 3 + 20 * 8)
        + (N_WRITES * 16 + WORDS * 8) + N_COPIES * (16 * 8 + WORDS * 8)
        + (16 * 8 + N_CONC * 16 + WORDS * 8);

    logic                  clk16, resetn;
    logic                  loading, loader_valid, gba_on;
    logic [7:0]            loader_data;
    logic                  dma_req, dma_ack, cpu_req, cpu_ack;
    gba_bus_pkg::dma_cmd_t dma_cmd;
    gba_bus_pkg::cpu_cmd_t cpu_cmd;
    logic [31:0]           cpu_rdata;

    logic [7:0] model_mem [0:REGION-1];
    int checks, errors, test_checks, test_errors;

    gba_mem_top dut0 (
        .clk16(clk16), .resetn(resetn),
        .loading(loading), .loader_data(loader_data), .loader_valid(loader_valid),
        .gba_on(gba_on),
        .dma_req(dma_req), .dma_cmd(dma_cmd), .dma_ack(dma_ack),
        .cpu_req(cpu_req), .cpu_cmd(cpu_cmd), .cpu_ack(cpu_ack), .cpu_rdata(cpu_rdata)
    );

    initial begin
        clk16 = 1'b0;
        forever #(CLK_PERIOD / 2) clk16 = ~clk16;
    end

    initial begin
        #(CLK_PERIOD * 4 * TEST_CYCLES);
        $display("watchdog expired after %0d cycles, run aborted", 4 * TEST_CYCLES);
        $display("Errors found");
        $finish;
    end

    //////////////////////////////////////////////////
    // checking and reporting
    //////////////////////////////////////////////////
    task automatic next_cycle();
        @(posedge clk16);
        #DRIVE_DLY;                 // drive and sample point
    endtask

    task automatic compare_word(string name, logic [31:0] got, logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic compare_flag(string name, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic report_failure(string what);
        errors++;
        $display("%s", what);
    endtask

    task automatic end_test(string name);
        $display("test %-26s %4d checks, %0d errors", name,
                 checks - test_checks, errors - test_errors);
        test_checks = checks;
        test_errors = errors;
    endtask

    //////////////////////////////////////////////////
    // byte model
    //////////////////////////////////////////////////
    function automatic int unit_bytes(gba_bus_pkg::acc_size_t size);
        case (size)
            gba_bus_pkg::ACC_BYTE: return 1;
            gba_bus_pkg::ACC_HALF: return 2;
            default:               return 4;
        endcase
    endfunction

    function automatic logic [31:0] model_word(int a);
        int w;
        w = a - a % 4;
        return {model_mem[w+3], model_mem[w+2], model_mem[w+1], model_mem[w]};
    endfunction

    // a unit covers its aligned block, each byte taken from its own lane
    task automatic model_write(int a, gba_bus_pkg::acc_size_t size, logic [31:0] wdata);
        int n;
        int base;
        n = unit_bytes(size);
        base = a - a % n;
        for (int j = 0; j < n; j++)
            model_mem[base + j] = wdata[8 * ((base + j) % 4) +: 8];
    endtask

    task automatic model_copy(gba_bus_pkg::dma_cmd_t c);
        logic [7:0] unit_buf [0:3];
        int n, s, d;
        n = unit_bytes(c.size);
        s = int'(c.src) - int'(c.src) % n;
        d = int'(c.dst) - int'(c.dst) % n;
        for (int k = 0; k < int'(c.count); k++) begin
            for (int j = 0; j < n; j++)
                unit_buf[j] = model_mem[s + j];
            for (int j = 0; j < n; j++)
                model_mem[d + j] = unit_buf[j];
            s += n;
            d += n;
        end
    endtask

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////
    task automatic load_image(int n);
        logic [7:0] b;
        int wait_n;
        loading = 1'b1;
        for (int i = 0; i < n; i++) begin
            b = 8'($urandom_range(255, 0));
            loader_data  = b;
            loader_valid = 1'b1;
            model_mem[i] = b;
            next_cycle();
            loader_valid = 1'b0;
            if (i == 0)
                compare_flag("gba_on", gba_on, 1'b0);
            next_cycle();
            next_cycle();           // one byte per 3 cycles
        end
        loading = 1'b0;
        wait_n = 0;
        while (!gba_on && wait_n < ACK_LIMIT) begin
            next_cycle();
            wait_n++;
        end
        if (!gba_on)
            report_failure($sformatf("gba_on did not rise after loading %0d bytes", n));
    endtask

    task automatic cpu_access(input int a, input logic write,
                              input gba_bus_pkg::acc_size_t size,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        int wait_n;
        cpu_cmd.addr  = gba_bus_pkg::byte_addr_t'(a);
        cpu_cmd.write = write;
        cpu_cmd.size  = size;
        cpu_cmd.wdata = wdata;
        cpu_req       = 1'b1;
        wait_n = 0;
        while (!cpu_ack && wait_n < ACK_LIMIT) begin
            next_cycle();
            wait_n++;
        end
        rdata = cpu_rdata;
        if (!cpu_ack)
            report_failure($sformatf("cpu access at 0x%0h got no ack", a));
        cpu_req = 1'b0;
        next_cycle();
        compare_flag("cpu_ack", cpu_ack, 1'b0);
    endtask

    task automatic check_word(int a);
        logic [31:0] got;
        cpu_access(a - a % 4, 1'b0, gba_bus_pkg::ACC_WORD, 32'h0, got);
        compare_word($sformatf("cpu_rdata @0x%03h", a - a % 4), got, model_word(a));
    endtask

    task automatic verify_region(int lo, int hi);
        for (int a = lo; a < hi; a += 4)
            check_word(a);
    endtask

    task automatic random_write(int lo, int hi);
        logic [31:0] rd;
        logic [31:0] wdata;
        gba_bus_pkg::acc_size_t size;
        int a;
        a     = $urandom_range(hi - 1, lo);
        size  = gba_bus_pkg::acc_size_t'($urandom_range(2, 0));
        wdata = $urandom();
        cpu_access(a, 1'b1, size, wdata, rd);
        model_write(a, size, wdata);
        check_word(a);
    endtask

    function automatic gba_bus_pkg::dma_cmd_t random_copy(int lo, int span, int min_count);
        gba_bus_pkg::dma_cmd_t c;
        c.size  = gba_bus_pkg::acc_size_t'($urandom_range(2, 0));
        c.count = 16'($urandom_range(16, min_count));
        c.src   = gba_bus_pkg::byte_addr_t'(lo + $urandom_range(span - 65, 0));
        c.dst   = gba_bus_pkg::byte_addr_t'(lo + $urandom_range(span - 65, 0));
        return c;
    endfunction

    task automatic dma_copy(gba_bus_pkg::dma_cmd_t c);
        int wait_n;
        dma_cmd = c;
        dma_req = 1'b1;
        wait_n = 0;
        while (!dma_ack && wait_n < 4 * ACK_LIMIT) begin
            next_cycle();
            wait_n++;
        end
        if (!dma_ack)
            report_failure($sformatf("dma copy of %0d units got no ack", c.count));
        else
            model_copy(c);
        dma_req = 1'b0;
        next_cycle();
        compare_flag("dma_ack", dma_ack, 1'b0);
    endtask

    //////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////
    initial begin
        int n;
        bit early;
        void'($urandom(32'h3eb0d21f));
        checks = 0;
        errors = 0;
        test_checks = 0;
        test_errors = 0;
        resetn = 1'b0;
        loading = 1'b0;
        loader_data = 8'h00;
        loader_valid = 1'b0;
        dma_req = 1'b0;
        dma_cmd = '0;
        cpu_req = 1'b0;
        cpu_cmd = '0;
        repeat (2) @(posedge clk16);
        #DRIVE_DLY;
        resetn = 1'b1;

        // 1: idle after reset, cpu held off until loaded
        compare_flag("gba_on", gba_on, 1'b0);
        compare_flag("dma_ack", dma_ack, 1'b0);
        compare_flag("cpu_ack", cpu_ack, 1'b0);
        cpu_cmd.size = gba_bus_pkg::ACC_WORD;
        cpu_req = 1'b1;                     // word read at 0
        repeat (10) next_cycle();
        early = 1'b0;
        fork
            load_image(REGION);
            while (!gba_on) begin
                early |= cpu_ack;
                next_cycle();
            end
        join
        if (early)
            report_failure("cpu_ack rose before gba_on");
        n = 0;
        while (!cpu_ack && n < ACK_LIMIT) begin
            next_cycle();
            n++;
        end
        if (!cpu_ack)
            report_failure("cpu request made before loading was never acked");
        else
            compare_word("cpu_rdata @0x000", cpu_rdata, model_word(0));
        cpu_req = 1'b0;
        next_cycle();
        compare_flag("cpu_ack", cpu_ack, 1'b0);
        end_test("reset and early cpu");

        // 2: reloads, first one ends in a partial word
        for (int i = 0; i < N_LOADS; i++) begin
            n = $urandom_range(64, 1);
            if (i == 0 && n % 4 == 0)
                n = n - 1;
            load_image(n);
            verify_region(0, n + 8);        // includes lanes past the image
        end
        end_test("cartridge load");

        // 3
        for (int i = 0; i < N_WRITES; i++)
            random_write(0, REGION);
        verify_region(0, REGION);
        end_test("cpu writes");

        // 4
        for (int i = 0; i < N_COPIES; i++) begin
            dma_copy(random_copy(0, REGION, 0));
            verify_region(0, REGION);
        end
        end_test("dma copies");

        // 5: dma in the low half, cpu in the high half
        fork
            dma_copy(random_copy(0, REGION / 2, 8));
            repeat (N_CONC) random_write(REGION / 2, REGION);
        join
        verify_region(0, REGION);
        end_test("dma with cpu traffic");

        n = dut0.chk0.fail_count;
        errors += n;
        $display("total %0d checks, %0d errors, %0d assertion failures", checks, errors, n);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule
